// File: list.f
hw/nc_pkg.sv
hw/block_count_store.sv
hw/top_row_buffer.sv
hw/nc_derive.sv
hw/nc_decoder_top.sv
verif/nc_decoder_tb.sv

// File: Makefile
# Verilator build and run of the nC decoder testbench

VERILATOR ?= verilator
TOP       ?= nc_decoder_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test FAILED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/nc_decoder_tb.sv
// random-stimulus testbench for nc_decoder_top; walks one frame and checks nc against a neighbour model
`timescale 1ns/1ps
`default_nettype none

module nc_decoder_tb
	import nc_pkg::*;
();

	localparam int MAX_CYCLES = 40000;

	logic               clk;
	logic               reset_n;
	logic [3:0]         cavlc_state;
	logic [3:0]         residual_state;
	logic [3:0]         mb_num_h;
	logic [3:0]         mb_num_v;
	logic [1:0]         i8x8;
	logic [1:0]         i4x4;
	logic               end_of_block;
	logic [COUNT_W-1:0] total_coeff;
	logic               end_of_mb;
	wire  [COUNT_W-1:0] nc;

	logic [31:0] lfsr;
	int          cycle_count;
	int          checks;
	int          errors;
	logic        timed_out;
	// TotalCoeff of every luma 4x4 block in the frame, row by row
	int          grid [0:4*int'(MB_ROWS)-1][0:4*int'(MB_COLS)-1];

	nc_decoder_top nc_decoder_top_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.cavlc_state    (cavlc_state),
		.residual_state (residual_state),
		.mb_num_h       (mb_num_h),
		.mb_num_v       (mb_num_v),
		.i8x8           (i8x8),
		.i4x4           (i4x4),
		.end_of_block   (end_of_block),
		.total_coeff    (total_coeff),
		.end_of_mb      (end_of_mb),
		.nc             (nc)
	);

	always #20 clk = ~clk;

	// ------------------------------------------------------------
	// random bits and waits
	// ------------------------------------------------------------
	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic wait_falling(input int n);
		int waited;
		waited = 0;
		while (waited < n && cycle_count < MAX_CYCLES)
		begin
			@(negedge clk);
			waited++;
			cycle_count++;
		end
		if (waited < n && !timed_out)
		begin
			timed_out = 1'b1;
			errors++;
			$display("timeout: the run took more than %0d clock cycles", MAX_CYCLES);
		end
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	// neighbours in frame coordinates, outside the frame means unavailable
	function automatic int model_nc(input int h, input int v, input int x, input int y);
		int gx;
		int gy;
		int na;
		int nb;
		gx = 4 * h + x;
		gy = 4 * v + y;
		na = 0;
		nb = 0;
		if (gx > 0)
			na = grid[gy][gx-1];
		if (gy > 0)
			nb = grid[gy-1][gx];
		if (gx > 0 && gy > 0)
			return (na + nb + 1) / 2;
		return na + nb;
	endfunction

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	// starts and ends on a falling edge
	task automatic run_block(input logic [3:0] res, input int i8, input int i4,
		input int exp_nc, input int count);
		logic [COUNT_W-1:0] exp_v;
		exp_v          = COUNT_W'(exp_nc);
		cavlc_state    = CAVLC_NANB;
		residual_state = res;
		i8x8           = 2'(i8);
		i4x4           = 2'(i4);
		wait_falling(1);
		cavlc_state = CAVLC_NC;
		wait_falling(1);
		cavlc_state = 4'd0;
		checks++;
		assert (nc == exp_v)
		else
		begin
			errors++;
			$display("mismatch at time %0t: nc %0d, expected %0d (mb %0d,%0d state %0d blk %0d.%0d)",
				$time, nc, exp_v, mb_num_h, mb_num_v, res, i8, i4);
		end
		end_of_block = 1'b1;
		total_coeff  = COUNT_W'(count);
		wait_falling(1);
		end_of_block = 1'b0;
	endtask

	task automatic run_macroblock(input int h, input int v);
		int mb_type;
		int mask;
		int pos;
		int count;
		int x;
		int y;
		mb_num_h = 4'(h);
		mb_num_v = 4'(v);
		// 0 skipped, 1 Intra16x16, otherwise plain luma
		take_bits(2, mb_type);
		if (mb_type != 0)
		begin
			take_bits(4, mask);
			if (mb_type == 1)
			begin
				// DC takes block 0 neighbours whatever the index says
				take_bits(4, pos);
				take_bits(5, count);
				run_block(RES_I16_DC, pos / 4, pos % 4, model_nc(h, v, 0, 0), count % 17);
			end
			for (int b8 = 0; b8 < 4; b8++)
			begin
				if (mask[b8])
				begin
					for (int b4 = 0; b4 < 4; b4++)
					begin
						x = 2 * (b8 % 2) + b4 % 2;
						y = 2 * (b8 / 2) + b4 / 2;
						take_bits(5, count);
						count = count % 17;
						run_block((mb_type == 1) ? RES_I16_AC : RES_LUMA, b8, b4,
							model_nc(h, v, x, y), count);
						grid[4*v+y][4*h+x] = count;
					end
				end
			end
			take_bits(3, count);
			run_block(RES_CHROMA_DC_CB, 0, 0, 31, count % 5);
			take_bits(3, count);
			run_block(RES_CHROMA_DC_CR, 0, 0, 31, count % 5);
		end
		end_of_mb = 1'b1;
		wait_falling(1);
		end_of_mb = 1'b0;
	endtask

	initial
	begin
		clk            = 1'b0;
		reset_n        = 1'b0;
		cavlc_state    = 4'd0;
		residual_state = 4'd0;
		mb_num_h       = 4'd0;
		mb_num_v       = 4'd0;
		i8x8           = 2'd0;
		i4x4           = 2'd0;
		end_of_block   = 1'b0;
		total_coeff    = '0;
		end_of_mb      = 1'b0;
		lfsr           = 32'h101f_e53c;
		cycle_count    = 0;
		checks         = 0;
		errors         = 0;
		timed_out      = 1'b0;
		foreach (grid[r, c])
			grid[r][c] = 0;

		wait_falling(4);
		reset_n = 1'b1;
		checks++;
		assert (nc == '0)
		else
		begin
			errors++;
			$display("mismatch at time %0t: nc %0d after reset, expected 0", $time, nc);
		end

		for (int v = 0; v < int'(MB_ROWS) && !timed_out; v++)
		begin
			for (int h = 0; h < int'(MB_COLS) && !timed_out; h++)
			begin
				run_macroblock(h, v);
			end
		end

		$display("nc checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/nc_decoder_top.sv
// top level of the nC derivation; connects the count store, the row buffer and the nC logic
`timescale 1ns/1ps
`default_nettype none

module nc_decoder_top
	import nc_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               reset_n,
	input  wire logic [3:0]         cavlc_state,
	input  wire logic [3:0]         residual_state,
	input  wire logic [3:0]         mb_num_h,
	input  wire logic [3:0]         mb_num_v,
	input  wire logic [1:0]         i8x8,
	input  wire logic [1:0]         i4x4,
	input  wire logic               end_of_block,
	input  wire logic [COUNT_W-1:0] total_coeff,
	input  wire logic               end_of_mb,
	output logic      [COUNT_W-1:0] nc
);

	logic [16*COUNT_W-1:0] cur_counts;
	logic [ROW_W-1:0]      left_counts;
	logic [ROW_W-1:0]      bottom_row;
	logic [ROW_W-1:0]      above_word;

	block_count_store block_count_store_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.residual_state (residual_state),
		.i8x8           (i8x8),
		.i4x4           (i4x4),
		.end_of_block   (end_of_block),
		.total_coeff    (total_coeff),
		.end_of_mb      (end_of_mb),
		.cur_counts     (cur_counts),
		.left_counts    (left_counts),
		.bottom_row     (bottom_row)
	);

	top_row_buffer top_row_buffer_i (
		.clk        (clk),
		.mb_num_h   (mb_num_h),
		.mb_num_v   (mb_num_v),
		.end_of_mb  (end_of_mb),
		.bottom_row (bottom_row),
		.above_word (above_word)
	);

	nc_derive nc_derive_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.cavlc_state    (cavlc_state),
		.residual_state (residual_state),
		.mb_num_h       (mb_num_h),
		.mb_num_v       (mb_num_v),
		.i8x8           (i8x8),
		.i4x4           (i4x4),
		.cur_counts     (cur_counts),
		.left_counts    (left_counts),
		.above_word     (above_word),
		.nc             (nc)
	);

endmodule

`default_nettype wire

// File: hw/nc_derive.sv
// picks the nA and nB neighbour counts of the current block and averages them into nc
`timescale 1ns/1ps
`default_nettype none

module nc_derive
	import nc_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	input  wire logic [3:0]            cavlc_state,
	input  wire logic [3:0]            residual_state,
	input  wire logic [3:0]            mb_num_h,
	input  wire logic [3:0]            mb_num_v,
	input  wire logic [1:0]            i8x8,
	input  wire logic [1:0]            i4x4,
	input  wire logic [16*COUNT_W-1:0] cur_counts,
	input  wire logic [ROW_W-1:0]      left_counts,
	input  wire logic [ROW_W-1:0]      above_word,
	output logic      [COUNT_W-1:0]    nc
);

	logic               is_luma;
	logic               is_dc;
	logic [1:0]         blk_x;
	logic [1:0]         blk_y;
	logic [3:0]         idx_a;
	logic [3:0]         idx_b;
	logic               na_avail;
	logic               nb_avail;
	logic [COUNT_W-1:0] na;
	logic [COUNT_W-1:0] nb;
	logic               na_avail_r;
	logic               nb_avail_r;
	logic [COUNT_W-1:0] na_r;
	logic [COUNT_W-1:0] nb_r;
	logic [COUNT_W:0]   sum;
	logic [COUNT_W:0]   sum_rnd;

	// ------------------------------------------------------------
	// block position
	// ------------------------------------------------------------
	assign is_dc   = (residual_state == RES_I16_DC);
	assign is_luma = is_dc || residual_state == RES_I16_AC || residual_state == RES_LUMA;

	// DC sits where block 0 is
	assign blk_x = is_dc ? 2'd0 : {i8x8[0], i4x4[0]};
	assign blk_y = is_dc ? 2'd0 : {i8x8[1], i4x4[1]};

	// left and upper neighbour inside the current macroblock
	assign idx_a = {blk_y, blk_x - 2'd1};
	assign idx_b = {blk_y - 2'd1, blk_x};

	// ------------------------------------------------------------
	// neighbour selection
	// ------------------------------------------------------------
	always_comb
	begin
		na_avail = 1'b0;
		na       = '0;
		nb_avail = 1'b0;
		nb       = '0;
		if (is_luma)
		begin
			if (blk_x != 2'd0)
			begin
				na_avail = 1'b1;
				na       = cur_counts[idx_a*COUNT_W +: COUNT_W];
			end
			else if (mb_num_h != 4'd0)
			begin
				na_avail = 1'b1;
				na       = left_counts[blk_y*COUNT_W +: COUNT_W];
			end
			if (blk_y != 2'd0)
			begin
				nb_avail = 1'b1;
				nb       = cur_counts[idx_b*COUNT_W +: COUNT_W];
			end
			else if (mb_num_v != 4'd0)
			begin
				nb_avail = 1'b1;
				nb       = above_word[blk_x*COUNT_W +: COUNT_W];
			end
		end
	end

	// latched in the neighbour fetch step
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			na_avail_r <= 1'b0;
			nb_avail_r <= 1'b0;
			na_r       <= '0;
			nb_r       <= '0;
		end
		else if (cavlc_state == CAVLC_NANB)
		begin
			na_avail_r <= na_avail;
			nb_avail_r <= nb_avail;
			na_r       <= na;
			nb_r       <= nb;
		end
	end

	// ------------------------------------------------------------
	// nc
	// ------------------------------------------------------------
	assign sum     = {1'b0, na_r} + {1'b0, nb_r};
	assign sum_rnd = sum + 6'd1;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			nc <= '0;
		else if (cavlc_state == CAVLC_NC)
		begin
			if (residual_state == RES_CHROMA_DC_CB || residual_state == RES_CHROMA_DC_CR)
				nc <= NC_CHROMA_DC;
			else if (na_avail_r && nb_avail_r)
				nc <= sum_rnd[COUNT_W:1];
			// at most one side is nonzero here, so the sum fits
			else
				nc <= sum[COUNT_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: hw/top_row_buffer.sv
// line buffer with the bottom-row counts of the macroblock row above, one word per column
`timescale 1ns/1ps
`default_nettype none

module top_row_buffer
	import nc_pkg::*;
(
	input  wire logic             clk,
	input  wire logic [3:0]       mb_num_h,
	input  wire logic [3:0]       mb_num_v,
	input  wire logic             end_of_mb,
	input  wire logic [ROW_W-1:0] bottom_row,
	output logic      [ROW_W-1:0] above_word
);

	logic [ROW_W-1:0] row_mem [0:MB_COLS-1];
	logic             wr_en;

	// ------------------------------------------------------------
	// write at end of macroblock
	// ------------------------------------------------------------
	// nothing below the last row reads it back
	assign wr_en = end_of_mb && (mb_num_v != MB_ROWS - 4'd1);

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			row_mem[mb_num_h] <= bottom_row;
		end
	end

	// ------------------------------------------------------------
	// read
	// ------------------------------------------------------------
	// same column as the current macroblock, so the word is the one above it
	assign above_word = row_mem[mb_num_h];

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// column index must address a real word for both read and write
	mb_num_h_range_a : assert property (
		@(posedge clk)
		mb_num_h < MB_COLS
	);

endmodule

`default_nettype wire

// File: hw/block_count_store.sv
// holds TotalCoeff of every 4x4 luma block in the current macroblock and its left neighbour column
`timescale 1ns/1ps
`default_nettype none

module block_count_store
	import nc_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	input  wire logic [3:0]            residual_state,
	input  wire logic [1:0]            i8x8,
	input  wire logic [1:0]            i4x4,
	input  wire logic                  end_of_block,
	input  wire logic [COUNT_W-1:0]    total_coeff,
	input  wire logic                  end_of_mb,
	output logic      [16*COUNT_W-1:0] cur_counts,
	output logic      [ROW_W-1:0]      left_counts,
	output logic      [ROW_W-1:0]      bottom_row
);

	logic [1:0] blk_x;
	logic [1:0] blk_y;
	logic [3:0] blk_idx;
	logic       store_en;

	// ------------------------------------------------------------
	// block position from the z-order indices
	// ------------------------------------------------------------
	assign blk_x   = {i8x8[0], i4x4[0]};
	assign blk_y   = {i8x8[1], i4x4[1]};
	// row-major, top-left is 0
	assign blk_idx = {blk_y, blk_x};

	// DC counts are not kept, only AC and plain luma
	assign store_en = end_of_block &&
		(residual_state == RES_I16_AC || residual_state == RES_LUMA);

	// ------------------------------------------------------------
	// current and left counts
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cur_counts  <= '0;
			left_counts <= '0;
		end
		else if (end_of_mb)
		begin
			// right column becomes the next macroblock's left column
			for (int r = 0; r < 4; r++)
			begin
				left_counts[r*COUNT_W +: COUNT_W] <= cur_counts[(r*4+3)*COUNT_W +: COUNT_W];
			end
			// uncoded and skipped blocks then read as zero
			cur_counts <= '0;
		end
		else if (store_en)
		begin
			cur_counts[blk_idx*COUNT_W +: COUNT_W] <= total_coeff;
		end
	end

	// blocks 12..15, handed to the line buffer at end of macroblock
	assign bottom_row = cur_counts[16*COUNT_W-1 -: ROW_W];

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// a 4x4 block never has more than 16 coefficients
	total_coeff_range_a : assert property (
		@(posedge clk) disable iff (!reset_n)
		end_of_block |-> (total_coeff <= 5'd16)
	);

endmodule

`default_nettype wire

// File: hw/nc_pkg.sv
// state codes, count widths and frame geometry shared by the nC blocks; import with nc_pkg::*
`default_nettype none

package nc_pkg;

	// ------------------------------------------------------------
	// count widths
	// ------------------------------------------------------------
	// one TotalCoeff count, 0..16, also the width of nc
	localparam int COUNT_W = 5;
	// four counts side by side, index 0 in the low bits
	localparam int ROW_W = 4 * COUNT_W;

	// ------------------------------------------------------------
	// frame geometry in macroblocks
	// ------------------------------------------------------------
	localparam logic [3:0] MB_COLS = 4'd11;
	localparam logic [3:0] MB_ROWS = 4'd9;

	// ------------------------------------------------------------
	// cavlc_state codes
	// ------------------------------------------------------------
	localparam logic [3:0] CAVLC_NANB = 4'b0001;
	localparam logic [3:0] CAVLC_NC   = 4'b0010;

	// ------------------------------------------------------------
	// residual_state codes
	// ------------------------------------------------------------
	localparam logic [3:0] RES_I16_DC       = 4'b0001;
	localparam logic [3:0] RES_I16_AC       = 4'b0010;
	localparam logic [3:0] RES_LUMA         = 4'b0011;
	localparam logic [3:0] RES_CHROMA_DC_CB = 4'b0100;
	localparam logic [3:0] RES_CHROMA_DC_CR = 4'b0101;

	// chroma DC always selects the -1 table
	localparam logic [COUNT_W-1:0] NC_CHROMA_DC = 5'd31;

endpackage

`default_nettype wire
